/* design/valu_defines.svh */
// Width, depth and count macros for the vector ALU lane
`ifndef VALU_DEFINES_SVH
`define VALU_DEFINES_SVH

// Datapath word and its byte enables
`define VALU_DATA_W      64
`define VALU_STRB_W      8

// Queue depths
`define VALU_INSN_DEPTH  4
`define VALU_RESQ_DEPTH  2

// Vector length and element counters
`define VALU_VL_W        8

// Instruction ids and done bits
`define VALU_NR_VINSN    8
`define VALU_ID_W        3

// Register file addressing in this lane
`define VALU_VREG_WORDS  32
`define VALU_ADDR_W      10

`endif

/* design/valu_pkg.sv */
// Element width and opcode enums with the operation and result word structs
`include "valu_defines.svh"

package valu_pkg;

  // Element width code
  // Elements per word is 8 >> code
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Element-wise opcodes
  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SUB  = 3'd1,
    ALU_AND  = 3'd2,
    ALU_OR   = 3'd3,
    ALU_XOR  = 3'd4,
    ALU_MINU = 3'd5,
    ALU_MAXU = 3'd6
  } alu_op_e;

  // One vector operation from the sequencer
  typedef struct packed {
    alu_op_e                 op;
    vew_e                    vew;
    logic [`VALU_VL_W-1:0]   vl;
    logic [4:0]              vd;
    logic [`VALU_ID_W-1:0]   id;
    logic                    use_vs1;
    logic                    use_vs2;
    // Scalar takes the place of operand a
    logic                    use_scalar;
    logic [`VALU_DATA_W-1:0] scalar;
    // Unmasked operation
    logic                    vm;
  } valu_op_t;

  // One result word toward the register file
  typedef struct packed {
    logic [`VALU_ID_W-1:0]   id;
    logic [`VALU_ADDR_W-1:0] addr;
    logic [`VALU_DATA_W-1:0] wdata;
    logic [`VALU_STRB_W-1:0] be;
  } valu_result_t;

endpackage

/* design/valu_if.sv */
// Issue interface and result interface between the lane stages
`timescale 1ns/100ps

// Issue head from the instruction queue to the issue stage
interface valu_issue_if;
  import valu_pkg::*;

  valu_op_t insn;
  logic     insn_valid;
  // Pulsed when the last operands of the head are consumed
  logic     issue_done;

  modport queue (
    output insn,
    output insn_valid,
    input  issue_done
  );

  modport issue (
    input  insn,
    input  insn_valid,
    output issue_done
  );
endinterface

// Result words from the issue stage into the result queue
interface valu_result_if;
  import valu_pkg::*;

  // Push only while full is low
  logic         push;
  valu_result_t word;
  logic         full;

  modport producer (
    output push,
    output word,
    input  full
  );

  modport consumer (
    input  push,
    input  word,
    output full
  );
endinterface

/* design/valu_insn_queue.sv */
// Instruction queue with accept, issue and commit pointers
`timescale 1ns/100ps
`include "valu_defines.svh"

module valu_insn_queue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  valu_pkg::valu_op_t    op_i,
  input  logic                  op_valid_i,
  output logic                  op_ready_o,
  valu_issue_if.queue           issue,
  output logic [`VALU_VL_W-1:0] commit_vl_o,
  output valu_pkg::vew_e        commit_vew_o,
  output logic [`VALU_ID_W-1:0] commit_id_o,
  output logic                  commit_valid_o,
  input  logic                  commit_done_i
);
  import valu_pkg::*;

  localparam int unsigned pnt_w = $clog2(`VALU_INSN_DEPTH);

  valu_op_t         queue_mem [`VALU_INSN_DEPTH];
  logic [pnt_w-1:0] accept_pnt_q;
  logic [pnt_w-1:0] issue_pnt_q;
  logic [pnt_w-1:0] commit_pnt_q;
  // Entries waiting for issue and for commit
  logic [pnt_w:0]   issue_cnt_q;
  logic [pnt_w:0]   commit_cnt_q;
  logic             ready_en_q;
  logic             accept;
  valu_op_t         commit_op;

  //////////////////////////////////////////////////
  // Accept side

  // Ready rises one cycle after reset
  // Full when every slot holds an uncommitted operation
  assign op_ready_o = ready_en_q && (commit_cnt_q != (pnt_w+1)'(`VALU_INSN_DEPTH));
  assign accept     = op_valid_i && op_ready_o;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      queue_mem[accept_pnt_q]    <= op_i;
      // Empty operations never wait for a mask
      queue_mem[accept_pnt_q].vm <= op_i.vm || (op_i.vl == '0);
    end
  end

  //////////////////////////////////////////////////
  // Issue and commit heads

  assign issue.insn       = queue_mem[issue_pnt_q];
  assign issue.insn_valid = (issue_cnt_q != '0);

  assign commit_op    = queue_mem[commit_pnt_q];
  assign commit_vl_o  = commit_op.vl;
  assign commit_vew_o = commit_op.vew;
  assign commit_id_o  = commit_op.id;

  // An empty head is held back until the issue stage has stepped past it
  assign commit_valid_o = (commit_cnt_q != '0) &&
                          ((commit_cnt_q != issue_cnt_q) || (commit_op.vl != '0));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_en_q   <= 1'b0;
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
    end else begin
      ready_en_q <= 1'b1;
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (issue.issue_done) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
      end
      if (commit_done_i) begin
        commit_pnt_q <= commit_pnt_q + 1'b1;
      end
      // Pointers wrap on their own since the depth is a power of two
      issue_cnt_q  <= issue_cnt_q + (pnt_w+1)'(accept) - (pnt_w+1)'(issue.issue_done);
      commit_cnt_q <= commit_cnt_q + (pnt_w+1)'(accept) - (pnt_w+1)'(commit_done_i);
    end
  end

endmodule

/* design/simd_alu.sv */
// Element-wise integer ALU over one word at a selectable element width
`timescale 1ns/100ps
`include "valu_defines.svh"

module simd_alu (
  input  logic [`VALU_DATA_W-1:0] operand_a_i,
  input  logic [`VALU_DATA_W-1:0] operand_b_i,
  input  valu_pkg::alu_op_e       op_i,
  input  valu_pkg::vew_e          vew_i,
  output logic [`VALU_DATA_W-1:0] result_o
);
  import valu_pkg::*;

  localparam int unsigned data_w = `VALU_DATA_W;

  // One result word per element width
  logic [3:0][data_w-1:0] res_w;

  // Works on zero-extended elements
  // Caller keeps only the low element bits so no carry crosses elements
  function automatic logic [data_w-1:0] elem_op(
    input alu_op_e           op,
    input logic [data_w-1:0] a,
    input logic [data_w-1:0] b
  );
    logic [data_w-1:0] r;
    case (op)
      ALU_ADD:  r = a + b;
      // Operand b minus operand a
      ALU_SUB:  r = b - a;
      ALU_AND:  r = a & b;
      ALU_OR:   r = a | b;
      ALU_XOR:  r = a ^ b;
      // Unsigned compare on the extended values
      ALU_MINU: r = (a < b) ? a : b;
      ALU_MAXU: r = (a > b) ? a : b;
      default:  r = '0;
    endcase
    return r;
  endfunction

  // Width k covers elements of 8 << k bits
  for (genvar k = 0; k < 4; k++) begin : g_width
    localparam int unsigned ew = 8 << k;
    for (genvar e = 0; e < data_w / ew; e++) begin : g_elem
      logic [data_w-1:0] full_res;
      assign full_res = elem_op(op_i,
                                data_w'(operand_a_i[ew*e +: ew]),
                                data_w'(operand_b_i[ew*e +: ew]));
      assign res_w[k][ew*e +: ew] = full_res[ew-1:0];
    end
  end

  // Select by element width code
  assign result_o = res_w[vew_i];

endmodule

/* design/valu_issue.sv */
// Issue stage with operand gathering, scalar replication and result word build
`timescale 1ns/100ps
`include "valu_defines.svh"

module valu_issue (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  valu_issue_if.issue                   issue,
  input  logic [1:0][`VALU_DATA_W-1:0]  operand_i,
  input  logic [1:0]                    operand_valid_i,
  output logic [1:0]                    operand_ready_o,
  input  logic [`VALU_STRB_W-1:0]       mask_i,
  input  logic                          mask_valid_i,
  output logic                          mask_ready_o,
  valu_result_if.producer               res
);
  import valu_pkg::*;

  localparam int unsigned vl_w   = `VALU_VL_W;
  localparam int unsigned addr_w = `VALU_ADDR_W;

  valu_op_t                insn;
  // Elements still to issue for the head
  logic [vl_w-1:0]         rem_q;
  logic                    started_q;
  logic [vl_w-1:0]         rem_cur;
  logic [vl_w-1:0]         epw;
  logic [vl_w-1:0]         elem_cnt;
  logic [vl_w-1:0]         word_idx;
  logic                    last;
  logic                    operands_ok;
  logic                    fire;
  logic                    skip;
  logic [`VALU_DATA_W-1:0] scalar_rep;
  logic [`VALU_DATA_W-1:0] operand_a;
  logic [`VALU_DATA_W-1:0] alu_result;
  logic [`VALU_STRB_W-1:0] tail_be;
  valu_result_t            word;

  assign insn = issue.insn;

  // Counter loads from vl on the first word of a new head
  assign rem_cur  = started_q ? rem_q : insn.vl;
  assign epw      = vl_w'(4'd8 >> insn.vew);
  assign last     = (rem_cur <= epw);
  assign elem_cnt = last ? rem_cur : epw;
  // Words already produced for this instruction
  assign word_idx = (insn.vl - rem_cur) >> (2'd3 - insn.vew);

  //////////////////////////////////////////////////
  // Firing condition

  assign operands_ok = (operand_valid_i[1] || !insn.use_vs2) &&
                       (operand_valid_i[0] || !insn.use_vs1) &&
                       (mask_valid_i || insn.vm);

  assign fire = issue.insn_valid && (rem_cur != '0) && operands_ok && !res.full;
  // Empty operation retires from issue without a word
  assign skip = issue.insn_valid && (rem_cur == '0);

  assign issue.issue_done = skip || (fire && last);
  assign operand_ready_o  = fire ? {insn.use_vs2, insn.use_vs1} : 2'b00;
  assign mask_ready_o     = fire && !insn.vm;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rem_q     <= '0;
      started_q <= 1'b0;
    end else if (issue.issue_done) begin
      started_q <= 1'b0;
    end else if (fire) begin
      rem_q     <= rem_cur - elem_cnt;
      started_q <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Datapath

  // Scalar copied into every element slot
  always_comb begin
    case (insn.vew)
      EW8:     scalar_rep = {8{insn.scalar[7:0]}};
      EW16:    scalar_rep = {4{insn.scalar[15:0]}};
      EW32:    scalar_rep = {2{insn.scalar[31:0]}};
      default: scalar_rep = insn.scalar;
    endcase
  end

  assign operand_a = insn.use_scalar ? scalar_rep : operand_i[0];

  simd_alu i_simd_alu (
    .operand_a_i (operand_a),
    .operand_b_i (operand_i[1]),
    .op_i        (insn.op),
    .vew_i       (insn.vew),
    .result_o    (alu_result)
  );

  // Byte b belongs to element b >> vew
  always_comb begin
    for (int b = 0; b < `VALU_STRB_W; b++) begin
      tail_be[b] = (vl_w'(b >> insn.vew) < elem_cnt);
    end
  end

  always_comb begin
    word.id    = insn.id;
    // Register base plus word index
    word.addr  = addr_w'(insn.vd) * addr_w'(`VALU_VREG_WORDS) + addr_w'(word_idx);
    word.wdata = alu_result;
    word.be    = tail_be & (insn.vm ? {`VALU_STRB_W{1'b1}} : mask_i);
  end

  assign res.push = fire;
  assign res.word = word;

endmodule

/* design/valu_result_queue.sv */
// Result buffer with register file handshake, commit counting and done bits
`timescale 1ns/100ps
`include "valu_defines.svh"

module valu_result_queue (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  valu_result_if.consumer           res,
  input  logic [`VALU_VL_W-1:0]     commit_vl_i,
  input  valu_pkg::vew_e            commit_vew_i,
  input  logic [`VALU_ID_W-1:0]     commit_id_i,
  input  logic                      commit_valid_i,
  output logic                      commit_done_o,
  output logic                      result_req_o,
  output logic [`VALU_ID_W-1:0]     result_id_o,
  output logic [`VALU_ADDR_W-1:0]   result_addr_o,
  output logic [`VALU_DATA_W-1:0]   result_wdata_o,
  output logic [`VALU_STRB_W-1:0]   result_be_o,
  input  logic                      result_gnt_i,
  output logic [`VALU_NR_VINSN-1:0] vinsn_done_o
);
  import valu_pkg::*;

  localparam int unsigned pnt_w = $clog2(`VALU_RESQ_DEPTH);
  localparam int unsigned vl_w  = `VALU_VL_W;

  valu_result_t     result_mem [`VALU_RESQ_DEPTH];
  logic [pnt_w-1:0] wr_pnt_q;
  logic [pnt_w-1:0] rd_pnt_q;
  logic [pnt_w:0]   cnt_q;
  valu_result_t     head;
  logic             gnt;
  // Remaining elements of the commit head
  logic [vl_w-1:0]  rem_q;
  logic             loaded_q;
  logic [vl_w-1:0]  rem_cur;
  logic [vl_w-1:0]  rem_nxt;
  logic [vl_w-1:0]  epw;

  //////////////////////////////////////////////////
  // Result buffer

  assign res.full = (cnt_q == (pnt_w+1)'(`VALU_RESQ_DEPTH));

  always_ff @(posedge clk_i) begin
    if (res.push) begin
      result_mem[wr_pnt_q] <= res.word;
    end
  end

  // Request held on the oldest word until granted
  assign head           = result_mem[rd_pnt_q];
  assign result_req_o   = (cnt_q != '0);
  assign result_id_o    = head.id;
  assign result_addr_o  = head.addr;
  assign result_wdata_o = head.wdata;
  assign result_be_o    = head.be;
  assign gnt            = result_req_o && result_gnt_i;

  //////////////////////////////////////////////////
  // Commit tracking

  assign epw     = vl_w'(4'd8 >> commit_vew_i);
  // Fresh head starts from its full vl
  assign rem_cur = loaded_q ? rem_q : commit_vl_i;

  // Clamp at zero for a partial tail word
  always_comb begin
    if (!gnt) begin
      rem_nxt = rem_cur;
    end else if (rem_cur > epw) begin
      rem_nxt = rem_cur - epw;
    end else begin
      rem_nxt = '0;
    end
  end

  assign commit_done_o = commit_valid_i && (rem_nxt == '0);

  // One-hot done pulse for the committing id
  always_comb begin
    vinsn_done_o = '0;
    if (commit_done_o) begin
      vinsn_done_o[commit_id_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
      rem_q    <= '0;
      loaded_q <= 1'b0;
    end else begin
      if (res.push) begin
        wr_pnt_q <= wr_pnt_q + 1'b1;
      end
      if (gnt) begin
        rd_pnt_q <= rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + (pnt_w+1)'(res.push) - (pnt_w+1)'(gnt);
      if (commit_done_o) begin
        loaded_q <= 1'b0;
      end else if (gnt) begin
        loaded_q <= 1'b1;
        rem_q    <= rem_nxt;
      end
    end
  end

endmodule

/* design/valu_top.sv */
// Top level of the vector ALU lane joining queue, issue stage and result queue
`timescale 1ns/100ps
`include "valu_defines.svh"

module valu_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Operations from the sequencer
  input  valu_pkg::valu_op_t           op_i,
  input  logic                         op_valid_i,
  output logic                         op_ready_o,
  // Operand queues and mask
  input  logic [1:0][`VALU_DATA_W-1:0] operand_i,
  input  logic [1:0]                   operand_valid_i,
  output logic [1:0]                   operand_ready_o,
  input  logic [`VALU_STRB_W-1:0]      mask_i,
  input  logic                         mask_valid_i,
  output logic                         mask_ready_o,
  // Vector register file write port
  output logic                         result_req_o,
  output logic [`VALU_ID_W-1:0]        result_id_o,
  output logic [`VALU_ADDR_W-1:0]      result_addr_o,
  output logic [`VALU_DATA_W-1:0]      result_wdata_o,
  output logic [`VALU_STRB_W-1:0]      result_be_o,
  input  logic                         result_gnt_i,
  output logic [`VALU_NR_VINSN-1:0]    vinsn_done_o
);
  import valu_pkg::*;

  // Commit head toward the result queue
  logic [`VALU_VL_W-1:0] commit_vl;
  vew_e                  commit_vew;
  logic [`VALU_ID_W-1:0] commit_id;
  logic                  commit_valid;
  logic                  commit_done;

  valu_issue_if  issue_if ();
  valu_result_if result_if ();

  valu_insn_queue i_insn_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .op_i           (op_i),
    .op_valid_i     (op_valid_i),
    .op_ready_o     (op_ready_o),
    .issue          (issue_if.queue),
    .commit_vl_o    (commit_vl),
    .commit_vew_o   (commit_vew),
    .commit_id_o    (commit_id),
    .commit_valid_o (commit_valid),
    .commit_done_i  (commit_done)
  );

  valu_issue i_issue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .issue           (issue_if.issue),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .mask_i          (mask_i),
    .mask_valid_i    (mask_valid_i),
    .mask_ready_o    (mask_ready_o),
    .res             (result_if.producer)
  );

  valu_result_queue i_result_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .res            (result_if.consumer),
    .commit_vl_i    (commit_vl),
    .commit_vew_i   (commit_vew),
    .commit_id_i    (commit_id),
    .commit_valid_i (commit_valid),
    .commit_done_o  (commit_done),
    .result_req_o   (result_req_o),
    .result_id_o    (result_id_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i),
    .vinsn_done_o   (vinsn_done_o)
  );

endmodule

/* bench/valu_properties.sv */
// Concurrent checks on the lane's register file handshake, op acceptance and done bits
`timescale 1ns/100ps
`include "valu_defines.svh"

module valu_properties (
  input logic                      clk_i,
  input logic                      rst_ni,
  input valu_pkg::valu_op_t        op_i,
  input logic                      op_valid_i,
  input logic                      op_ready_i,
  input logic                      result_req_i,
  input logic [`VALU_ID_W-1:0]     result_id_i,
  input logic [`VALU_ADDR_W-1:0]   result_addr_i,
  input logic [`VALU_DATA_W-1:0]   result_wdata_i,
  input logic [`VALU_STRB_W-1:0]   result_be_i,
  input logic                      result_gnt_i,
  input logic [`VALU_NR_VINSN-1:0] vinsn_done_i
);
  import valu_pkg::*;

  logic                      accept;
  // Accepted but not yet done
  logic [2:0]                outstanding_q;
  logic [`VALU_NR_VINSN-1:0] pending_q;
  // Count of failed assertions
  int                        assert_fail_cnt = 0;

  assign accept = op_valid_i && op_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= '0;
      pending_q     <= '0;
    end else begin
      outstanding_q <= outstanding_q + 3'(accept) - 3'(|vinsn_done_i);
      pending_q     <= pending_q & ~vinsn_done_i;
      if (accept) begin
        pending_q[op_i.id] <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Register file request

  // Request and payload held until granted
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_req_i && !result_gnt_i |=> result_req_i &&
    $stable({result_id_i, result_addr_i, result_wdata_i, result_be_i}))
    else begin
      $error("result request dropped or changed before its grant");
      assert_fail_cnt++;
    end

  //////////////////////////////////////////////////
  // Back-pressure and done bits

  a_full_blocks: assert property (@(posedge clk_i) disable iff (!rst_ni)
    outstanding_q == 3'd4 |-> !op_ready_i)
    else begin
      $error("op_ready_o high with four operations uncommitted");
      assert_fail_cnt++;
    end

  a_done_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(vinsn_done_i))
    else begin
      $error("more than one done bit in a cycle");
      assert_fail_cnt++;
    end

  // Once per accepted id
  a_done_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (vinsn_done_i & ~pending_q) == '0)
    else begin
      $error("done bit for an id that is not outstanding");
      assert_fail_cnt++;
    end

  a_done_narrow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    |vinsn_done_i |=> (vinsn_done_i & $past(vinsn_done_i)) == '0)
    else begin
      $error("done bit held longer than one cycle");
      assert_fail_cnt++;
    end

  a_done_on_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    |vinsn_done_i |-> result_req_i && result_gnt_i)
    else begin
      $error("done bit without a granted word");
      assert_fail_cnt++;
    end

endmodule

bind valu_top valu_properties i_properties (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .op_i           (op_i),
  .op_valid_i     (op_valid_i),
  .op_ready_i     (op_ready_o),
  .result_req_i   (result_req_o),
  .result_id_i    (result_id_o),
  .result_addr_i  (result_addr_o),
  .result_wdata_i (result_wdata_o),
  .result_be_i    (result_be_o),
  .result_gnt_i   (result_gnt_i),
  .vinsn_done_i   (vinsn_done_o)
);

/* bench/valu_tb.sv */
// Testbench for the vector ALU lane with LFSR stimulus, reference model, watchdog and summary
`timescale 1ns/100ps
`include "valu_defines.svh"

module valu_tb;
  import valu_pkg::*;

  localparam int num_tests       = 56;
  localparam int cycles_per_word = 40;
  localparam int data_w          = `VALU_DATA_W;
  localparam int addr_w          = `VALU_ADDR_W;

  // Expected register file write
  // Last marks the final word of a test
  typedef struct packed {
    logic [`VALU_ID_W-1:0]   id;
    logic [`VALU_ADDR_W-1:0] addr;
    logic [`VALU_DATA_W-1:0] wdata;
    logic [`VALU_STRB_W-1:0] be;
    logic                    last;
  } exp_word_t;

  logic                         clk_i;
  logic                         rst_ni;
  valu_op_t                     op_i;
  logic                         op_valid_i;
  logic                         op_ready_o;
  logic [1:0][`VALU_DATA_W-1:0] operand_i;
  logic [1:0]                   operand_valid_i;
  logic [1:0]                   operand_ready_o;
  logic [`VALU_STRB_W-1:0]      mask_i;
  logic                         mask_valid_i;
  logic                         mask_ready_o;
  logic                         result_req_o;
  logic [`VALU_ID_W-1:0]        result_id_o;
  logic [`VALU_ADDR_W-1:0]      result_addr_o;
  logic [`VALU_DATA_W-1:0]      result_wdata_o;
  logic [`VALU_STRB_W-1:0]      result_be_o;
  logic                         result_gnt_i;
  logic [`VALU_NR_VINSN-1:0]    vinsn_done_o;

  // Streams held in the order the DUT consumes them
  valu_op_t                op_q [$];
  logic [`VALU_DATA_W-1:0] vs1_q [$];
  logic [`VALU_DATA_W-1:0] vs2_q [$];
  logic [`VALU_STRB_W-1:0] mask_q [$];
  exp_word_t               exp_q [$];
  valu_op_t                test_op [num_tests];

  logic [31:0] lfsr_q;
  logic        gen_done;
  int          total_words;
  int          tests_done;
  int          pass_cnt;
  int          fail_cnt;
  int          check_cnt;
  int          err_cnt;
  int          test_err;

  valu_top DUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .op_i            (op_i),
    .op_valid_i      (op_valid_i),
    .op_ready_o      (op_ready_o),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .mask_i          (mask_i),
    .mask_valid_i    (mask_valid_i),
    .mask_ready_o    (mask_ready_o),
    .result_req_o    (result_req_o),
    .result_id_o     (result_id_o),
    .result_addr_o   (result_addr_o),
    .result_wdata_o  (result_wdata_o),
    .result_be_o     (result_be_o),
    .result_gnt_i    (result_gnt_i),
    .vinsn_done_o    (vinsn_done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Random source and reference model

  // Fibonacci LFSR with taps 32 22 2 1
  // One step per bit taken
  function automatic logic [63:0] draw_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[62:0], fb};
    end
    return v;
  endfunction

  // One element on zero-extended values
  // Caller trims to the element width
  function automatic logic [63:0] elem_result(input alu_op_e op, input logic [63:0] a,
                                              input logic [63:0] b);
    case (op)
      ALU_ADD:  return a + b;
      // vs2 minus vs1
      ALU_SUB:  return b - a;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_MINU: return (a < b) ? a : b;
      ALU_MAXU: return (a > b) ? a : b;
      default:  return '0;
    endcase
  endfunction

  // Opcode and width sweep over two vector operands
  // Second half repeats the sweep with the scalar in place of operand a
  task automatic build_test(input int t);
    valu_op_t    op;
    exp_word_t   xw;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] emask;
    logic [63:0] rep;
    logic [63:0] res;
    logic [7:0]  mask;
    logic [7:0]  tail;
    int          ew;
    int          epw;
    int          nwords;
    int          cnt;
    op            = '0;
    op.op         = alu_op_e'(t % 7);
    op.vew        = vew_e'((t / 7) % 4);
    op.vl         = 8'(1 + draw_bits(5));
    op.vd         = 5'(draw_bits(5));
    op.id         = 3'(t % `VALU_NR_VINSN);
    op.use_scalar = (t >= num_tests / 2);
    // Operand a comes from vs1 only when no scalar replaces it
    op.use_vs1    = !op.use_scalar;
    op.use_vs2    = 1'b1;
    op.scalar     = draw_bits(data_w);
    op.vm         = 1'(draw_bits(1));
    op_q.push_back(op);
    test_op[t] = op;
    ew     = 8 << op.vew;
    epw    = 8 >> op.vew;
    nwords = (int'(op.vl) + epw - 1) / epw;
    emask  = {64{1'b1}} >> (64 - ew);
    // Scalar copied into every element slot
    rep = '0;
    for (int e = 0; e < epw; e++) begin
      rep = rep | ((op.scalar & emask) << (e * ew));
    end
    for (int w = 0; w < nwords; w++) begin
      a    = op.use_scalar ? rep : draw_bits(data_w);
      b    = draw_bits(data_w);
      mask = 8'(draw_bits(8));
      if (!op.use_scalar) begin
        vs1_q.push_back(a);
      end
      vs2_q.push_back(b);
      if (!op.vm) begin
        mask_q.push_back(mask);
      end
      res = '0;
      for (int e = 0; e < epw; e++) begin
        ea  = (a >> (e * ew)) & emask;
        eb  = (b >> (e * ew)) & emask;
        res = res | ((elem_result(op.op, ea, eb) & emask) << (e * ew));
      end
      // Active elements in this word, each spanning 1 << vew bytes
      cnt      = int'(op.vl) - w * epw;
      cnt      = (cnt < epw) ? cnt : epw;
      tail     = 8'((16'h1 << (cnt << op.vew)) - 16'h1);
      xw.id    = op.id;
      xw.addr  = addr_w'(int'(op.vd) * `VALU_VREG_WORDS + w);
      xw.wdata = res;
      xw.be    = tail & (op.vm ? 8'hff : mask);
      xw.last  = (w == nwords - 1);
      exp_q.push_back(xw);
    end
    total_words += nwords;
  endtask

  //////////////////////////////////////////////////
  // Checks on every grant

  task automatic check_field(input string name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    check_cnt++;
    assert (act_val == exp_val) else begin
      $display("error: time %0t %s expected %h actual %h", $time, name, exp_val, act_val);
      test_err++;
    end
  endtask

  task automatic finish_test();
    valu_op_t op;
    op = test_op[tests_done];
    $display("test %0d %s %s vl %0d: %s", tests_done, op.op.name(), op.vew.name(), op.vl,
             (test_err == 0) ? "ok" : "mismatch");
    if (test_err == 0) begin
      pass_cnt++;
    end else begin
      fail_cnt++;
    end
    err_cnt   += test_err;
    test_err   = 0;
    tests_done++;
  endtask

  task automatic check_grant();
    exp_word_t                 xw;
    logic [`VALU_NR_VINSN-1:0] exp_done;
    if (exp_q.size() == 0) begin
      $display("error: time %0t a word was granted that no test expects", $time);
      err_cnt++;
    end else begin
      xw       = exp_q.pop_front();
      // Done pulse only with the last word of its instruction
      exp_done = '0;
      if (xw.last) begin
        exp_done[xw.id] = 1'b1;
      end
      check_field("result_id_o", 64'(xw.id), 64'(result_id_o));
      check_field("result_addr_o", 64'(xw.addr), 64'(result_addr_o));
      check_field("result_wdata_o", xw.wdata, result_wdata_o);
      check_field("result_be_o", 64'(xw.be), 64'(result_be_o));
      check_field("vinsn_done_o", 64'(exp_done), 64'(vinsn_done_o));
      if (xw.last) begin
        finish_test();
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Input driving

  task automatic drive_inputs();
    op_valid_i         = (op_q.size() != 0);
    op_i               = '0;
    operand_valid_i[0] = (vs1_q.size() != 0);
    operand_valid_i[1] = (vs2_q.size() != 0);
    operand_i          = '0;
    mask_valid_i       = (mask_q.size() != 0);
    mask_i             = '0;
    if (op_valid_i) begin
      op_i = op_q[0];
    end
    if (operand_valid_i[0]) begin
      operand_i[0] = vs1_q[0];
    end
    if (operand_valid_i[1]) begin
      operand_i[1] = vs2_q[0];
    end
    if (mask_valid_i) begin
      mask_i = mask_q[0];
    end
    // Grant withheld about one cycle in four
    result_gnt_i = (draw_bits(2) != 64'd0);
  endtask

  // Handshakes sampled mid-cycle
  // Streams advance after the edge
  initial begin : stream_driver
    logic op_hs;
    logic vs1_hs;
    logic vs2_hs;
    logic mask_hs;
    @(posedge rst_ni);
    forever begin
      @(negedge clk_i);
      op_hs   = op_valid_i && op_ready_o;
      vs1_hs  = operand_valid_i[0] && operand_ready_o[0];
      vs2_hs  = operand_valid_i[1] && operand_ready_o[1];
      mask_hs = mask_valid_i && mask_ready_o;
      if (result_req_o && result_gnt_i) begin
        check_grant();
      end
      @(posedge clk_i);
      #1;
      if (op_hs) begin
        void'(op_q.pop_front());
      end
      if (vs1_hs) begin
        void'(vs1_q.pop_front());
      end
      if (vs2_hs) begin
        void'(vs2_q.pop_front());
      end
      if (mask_hs) begin
        void'(mask_q.pop_front());
      end
      drive_inputs();
    end
  end

  //////////////////////////////////////////////////
  // Run control

  initial begin
    rst_ni          = 1'b0;
    op_i            = '0;
    op_valid_i      = 1'b0;
    operand_i       = '0;
    operand_valid_i = 2'b00;
    mask_i          = '0;
    mask_valid_i    = 1'b0;
    result_gnt_i    = 1'b0;
    lfsr_q          = 32'h5900_90a9;
    gen_done        = 1'b0;
    total_words     = 0;
    tests_done      = 0;
    pass_cnt        = 0;
    fail_cnt        = 0;
    check_cnt       = 0;
    err_cnt         = 0;
    test_err        = 0;
    for (int t = 0; t < num_tests; t++) begin
      build_test(t);
    end
    gen_done = 1'b1;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    wait (tests_done == num_tests);
    repeat (2) @(posedge clk_i);
    $display("summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors, %0d %s",
             tests_done, pass_cnt, fail_cnt, check_cnt, err_cnt,
             DUT.i_properties.assert_fail_cnt, "property failures");
    if (err_cnt == 0 && fail_cnt == 0 && DUT.i_properties.assert_fail_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Budget scales with the number of result words
  initial begin : watchdog
    wait (gen_done);
    repeat (total_words * cycles_per_word) @(posedge clk_i);
    $display("timeout: only %0d of %0d tests finished within %0d cycles",
             tests_done, num_tests, total_words * cycles_per_word);
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+design
design/valu_pkg.sv
design/valu_if.sv
design/valu_insn_queue.sv
design/simd_alu.sv
design/valu_issue.sv
design/valu_result_queue.sv
design/valu_top.sv
bench/valu_properties.sv
bench/valu_tb.sv

/* Makefile */
# Verilator flow for the vector ALU lane

VERILATOR ?= verilator
TOP       ?= valu_tb
RTL_TOP   ?= valu_top
FILELIST  ?= filelist.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if grep -q "%Error" $(LOG); then echo "assertion failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
